// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_zbuf
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= *** TEST FAILED ***
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF '$(FAIL_MSG)' $(LOG) || ! grep -qF '$(PASS_MSG)' $(LOG) || \
	   [ $$status -ne 0 ]; then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: lane_adder.sv
`default_nettype none

`include "zbuf_params.svh"

module lane_adder
  import zbuf_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clear_i,
  input  logic push_i,
  input  row_t row_i,
  input  row_t x_i,
  output logic fill_o,
  output row_t row_o
);

  // Row data trails the push by one cycle
  logic push_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      push_q <= 1'b0;
      fill_o <= 1'b0;
    end else if (clear_i) begin
      push_q <= 1'b0;
      fill_o <= 1'b0;
    end else begin
      push_q <= push_i;
      fill_o <= push_q;
    end
  end

  // Lane-wise sum, wraps at the element width
  always_ff @(posedge clk_i) begin
    if (push_q) begin
      for (int w = 0; w < `ZB_WIDTH; w++) begin
        row_o[w] <= row_i[w] + x_i[w];
      end
    end
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
zbuf_pkg.sv
zbuf_scm.sv
zbuf.sv
lane_adder.sv
zbuf_seq.sv
zbuf_top.sv
zbuf_props.sv
tb_clkgen.sv
tb_zbuf.sv

// File: tb_clkgen.sv
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD     = 40,
  parameter int RST_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  initial clk_o = 1'b0;
  always #(PERIOD / 2) clk_o = ~clk_o;

  // Reset released on a rising edge after RST_CYCLES cycles
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_zbuf.sv
`default_nettype none

`include "zbuf_params.svh"

module tb_zbuf
  import zbuf_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DW        = `ZB_DEPTH * `ZB_ELEM;
  localparam int NUM_TILES = 9;
  // Worst-case budget per tile, in clock cycles
  localparam int TIMEOUT   = NUM_TILES * (`ZB_WIDTH * 2 + `ZB_DEPTH + 8) * 4;

  // ready_mode 0 keeps z_ready high, 1 toggles it, 2 stalls most cycles
  typedef struct packed {
    logic [2:0]                   rows;
    logic [2:0]                   cols;
    logic [1:0]                   ready_mode;
    logic                         clr;
    row_t                         x;
    logic [`ZB_WIDTH-1:0][DW-1:0] y;
  } tile_t;

  logic            clk, rst_n, clear;
  zbuf_cfg_t       cfg;
  row_t            x_lanes;
  logic            y_valid, y_ready, z_valid, z_ready, tile_done;
  logic [DW-1:0]   y_data, z_data;
  logic [DW/8-1:0] z_strb;

  tile_t       tiles [NUM_TILES];
  logic [31:0] seed;
  int          errors = 0;
  int          checked = 0;
  int          cycles = 0;

  tb_clkgen #(.PERIOD(40), .RST_CYCLES(5)) i_clkgen (.clk_o(clk), .rst_no(rst_n));

  zbuf_top i_zbuf_top (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .clear_i     (clear),
    .cfg_i       (cfg),
    .x_i         (x_lanes),
    .y_valid_i   (y_valid),
    .y_data_i    (y_data),
    .z_ready_i   (z_ready),
    .y_ready_o   (y_ready),
    .z_valid_o   (z_valid),
    .z_data_o    (z_data),
    .z_strb_o    (z_strb),
    .tile_done_o (tile_done)
  );

  bind zbuf zbuf_props i_zbuf_props (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (clear_i),
    .ctrl_i   (ctrl_i),
    .flags_i  (flags_o),
    .z_data_i (z_data_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic logic [31:0] next_rand();
    seed = xorshift32(seed);
    return seed;
  endfunction

  function automatic logic ready_draw(input logic [1:0] mode);
    logic [31:0] r;
    r = next_rand();
    case (mode)
      2'd0:    return 1'b1;
      2'd1:    return r[7];
      default: return r[7:6] == 2'b00;
    endcase
  endfunction

  // Z element r of column c is Y element r plus x lane c, wrapped to 16 bits
  function automatic logic [DW-1:0] expected_col(input tile_t tl, input int c);
    logic [DW-1:0] col;
    col = '0;
    for (int r = 0; r < int'(tl.rows); r++) begin
      col[r*`ZB_ELEM +: `ZB_ELEM] = tl.y[c][r*`ZB_ELEM +: `ZB_ELEM] + tl.x[c];
    end
    return col;
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  task automatic add_tile(input int idx, input int rows, input int cols, input row_t x,
                          input int mode, input bit clr);
    tiles[idx].rows       = 3'(rows);
    tiles[idx].cols       = 3'(cols);
    tiles[idx].ready_mode = 2'(mode);
    tiles[idx].clr        = clr;
    tiles[idx].x          = x;
    for (int c = 0; c < `ZB_WIDTH; c++) begin
      tiles[idx].y[c] = {next_rand(), next_rand()};
    end
  endtask

  task automatic run_tile(input int t);
    tile_t           tl;
    int              got;
    logic            last;
    logic [DW-1:0]   exp_d, mask_d;
    logic [DW/8-1:0] exp_s;
    tl = tiles[t];
    cfg     <= '{rows: tl.rows, cols: tl.cols};
    x_lanes <= tl.x;
    for (int c = 0; c < int'(tl.cols); c++) begin
      y_valid <= 1'b1;
      y_data  <= tl.y[c];
      @(posedge clk);
      while (!y_ready) @(posedge clk);
    end
    y_valid <= 1'b0;
    if (tl.clr) begin
      // Cut the tile off in the middle of its push burst
      repeat (2) @(posedge clk);
      clear <= 1'b1;
      @(posedge clk);
      clear <= 1'b0;
      @(posedge clk);
      if (!y_ready || z_valid) report_error($sformatf("tile %0d not idle after clear", t));
      return;
    end
    got = 0;
    z_ready <= ready_draw(tl.ready_mode);
    while (got < int'(tl.cols)) begin
      @(posedge clk);
      if (y_ready) report_error($sformatf("tile %0d y_ready high before tile_done", t));
      if (z_valid && z_ready) begin
        exp_d  = expected_col(tl, got);
        mask_d = '0;
        exp_s  = '0;
        for (int r = 0; r < int'(tl.rows); r++) begin
          mask_d[r*`ZB_ELEM +: `ZB_ELEM] = '1;
          exp_s[r*(`ZB_ELEM/8) +: `ZB_ELEM/8] = '1;
        end
        if ((z_data & mask_d) != exp_d) begin
          report_error($sformatf("tile %0d col %0d data %h, expected %h",
                                 t, got, z_data & mask_d, exp_d));
        end
        if (z_strb != exp_s) begin
          report_error($sformatf("tile %0d col %0d strobe %b, expected %b",
                                 t, got, z_strb, exp_s));
        end
        last = got == int'(tl.cols) - 1;
        if (tile_done != last) begin
          report_error($sformatf("tile %0d col %0d tile_done %b, expected %b",
                                 t, got, tile_done, last));
        end
        checked++;
        got++;
      end else if (tile_done) begin
        report_error($sformatf("tile %0d tile_done without a column transfer", t));
      end
      z_ready <= ready_draw(tl.ready_mode);
    end
    z_ready <= 1'b0;
    @(posedge clk);
    if (!y_ready) report_error($sformatf("tile %0d y_ready did not return", t));
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("Timeout: tiles still running after %0d cycles", TIMEOUT);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    clear   = 1'b0;
    cfg     = '{rows: 3'd4, cols: 3'd4};
    x_lanes = '0;
    y_valid = 1'b0;
    y_data  = '0;
    z_ready = 1'b0;
    seed    = 32'h4f4a311a;
    add_tile(0, 4, 4, {16'd40, 16'd30, 16'd20, 16'd10}, 0, 1'b0);
    add_tile(1, 1, 1, {16'd0, 16'd0, 16'd0, 16'd5}, 1, 1'b0);
    add_tile(2, 2, 3, {16'd0, 16'd300, 16'd200, 16'd100}, 1, 1'b0);
    add_tile(3, 4, 1, {16'd0, 16'd0, 16'd0, 16'hfff0}, 0, 1'b0);
    // Large lane operands force wrapping sums
    add_tile(4, 4, 4, {16'hc000, 16'h8001, 16'hffff, 16'h7fff}, 1, 1'b0);
    add_tile(5, 3, 4, {16'd7, 16'd6, 16'd5, 16'd4}, 2, 1'b0);
    add_tile(6, 4, 4, {16'h0101, 16'h0202, 16'h0303, 16'h0404}, 2, 1'b0);
    add_tile(7, 4, 4, {16'd1, 16'd1, 16'd1, 16'd1}, 0, 1'b1);
    add_tile(8, 2, 2, {16'd0, 16'd0, 16'h8000, 16'h1234}, 1, 1'b0);
    wait (rst_n === 1'b1);
    @(posedge clk);
    if (!y_ready || z_valid) report_error("wrong handshake state after reset");
    for (int t = 0; t < NUM_TILES; t++) begin
      run_tile(t);
    end
    errors = errors + int'(i_zbuf_top.i_zbuf.i_zbuf_props.fail_count);
    $display("Errors: %0d, columns checked: %0d", errors, checked);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: zbuf.sv
`default_nettype none

`include "zbuf_params.svh"

module zbuf
  import zbuf_pkg::*;
#(
  localparam int unsigned W   = `ZB_WIDTH,
  localparam int unsigned D   = `ZB_DEPTH,
  localparam int unsigned E   = `ZB_ELEM,
  localparam int unsigned DW  = D * E,
  localparam int unsigned DIW = $clog2(D),
  localparam int unsigned WIW = $clog2(W)
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          clear_i,
  input  zbuf_ctrl_t    ctrl_i,
  input  row_t          row_i,
  input  logic [DW-1:0] y_data_i,
  output row_t          row_o,
  output logic [DW-1:0] z_data_o,
  output logic [DW/8-1:0] z_strb_o,
  output zbuf_flags_t   flags_o
);

  typedef enum logic [1:0] {
    EMPTY,
    LOADED,
    PUSHED
  } state_e;

  state_e state_q, state_d;

  logic [WIW-1:0] w_idx_q, s_idx_q, s_idx_nxt;
  logic [DIW-1:0] d_idx_q, f_idx_q;
  logic [2:0]     rows_m1, cols_m1;
  logic load_en, y_acc, store_en, z_xfer;
  logic last_col_in, last_push, last_fill, last_col_out;

  assign rows_m1 = ctrl_i.cfg.rows - 3'd1;
  assign cols_m1 = ctrl_i.cfg.cols - 3'd1;

  // Y is taken only once the previous tile has fully drained
  assign load_en  = state_q == EMPTY && !ctrl_i.fill && d_idx_q == '0 &&
                    f_idx_q == '0 && s_idx_q == '0;
  assign y_acc    = load_en && ctrl_i.y_valid;
  assign store_en = state_q == PUSHED;
  assign z_xfer   = store_en && ctrl_i.ready;

  assign last_col_in  = w_idx_q == cols_m1[WIW-1:0];
  assign last_push    = ctrl_i.y_push_enable && d_idx_q == rows_m1[DIW-1:0];
  assign last_fill    = ctrl_i.fill && f_idx_q == rows_m1[DIW-1:0];
  assign last_col_out = s_idx_q == cols_m1[WIW-1:0];
  assign s_idx_nxt    = last_col_out ? '0 : s_idx_q + 1'b1;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      EMPTY:   if (y_acc && last_col_in) state_d = LOADED;
      LOADED:  if (last_fill) state_d = PUSHED;
      PUSHED:  if (z_xfer && last_col_out) state_d = EMPTY;
      default: state_d = EMPTY;
    endcase
  end

  // State and the load, push, fill and store index counters
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= EMPTY;
      w_idx_q <= '0;
      d_idx_q <= '0;
      f_idx_q <= '0;
      s_idx_q <= '0;
    end else if (clear_i) begin
      state_q <= EMPTY;
      w_idx_q <= '0;
      d_idx_q <= '0;
      f_idx_q <= '0;
      s_idx_q <= '0;
    end else begin
      state_q <= state_d;
      if (y_acc) w_idx_q <= last_col_in ? '0 : w_idx_q + 1'b1;
      if (ctrl_i.y_push_enable) d_idx_q <= last_push ? '0 : d_idx_q + 1'b1;
      if (ctrl_i.fill) f_idx_q <= last_fill ? '0 : f_idx_q + 1'b1;
      if (z_xfer) s_idx_q <= s_idx_nxt;
    end
  end

  // Column 0 is fetched with the last fill, later ones on each transfer
  zbuf_scm i_scm (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .row_we_i    (ctrl_i.fill),
    .col_we_i    (y_acc),
    .row_waddr_i (f_idx_q),
    .col_waddr_i (w_idx_q),
    .row_wdata_i (row_i),
    .col_wdata_i (y_data_i),
    .row_re_i    (ctrl_i.y_push_enable),
    .col_re_i    (last_fill || z_xfer),
    .row_raddr_i (d_idx_q),
    .col_raddr_i (store_en ? s_idx_nxt : '0),
    .row_rdata_o (row_o),
    .col_rdata_o (z_data_o)
  );

  // Two strobe bytes per used row
  always_comb begin
    z_strb_o = '0;
    for (int r = 0; r < D; r++) begin
      if (r < int'(ctrl_i.cfg.rows)) z_strb_o[r*(E/8) +: E/8] = '1;
    end
  end

  assign flags_o.y_ready  = load_en;
  assign flags_o.loaded   = (y_acc && last_col_in) || state_q == LOADED;
  assign flags_o.y_pushed = last_push;
  assign flags_o.z_valid  = store_en;
  assign flags_o.empty    = z_xfer && last_col_out;

endmodule

`default_nettype wire

// File: zbuf_params.svh
`ifndef ZBUF_PARAMS_SVH
`define ZBUF_PARAMS_SVH

// Lanes across a tile, one per column
`define ZB_WIDTH 4

// Elements stacked in one column word
`define ZB_DEPTH 4

// Element width in bits, two's complement
`define ZB_ELEM 16

`endif

// File: zbuf_pkg.sv
`default_nettype none

`include "zbuf_params.svh"

package zbuf_pkg;

  // Tile shape, both fields count from 1
  typedef struct packed {
    logic [2:0] rows;
    logic [2:0] cols;
  } zbuf_cfg_t;

  // Strobes into the buffer
  typedef struct packed {
    logic      y_valid;
    logic      fill;
    logic      y_push_enable;
    logic      ready;
    zbuf_cfg_t cfg;
  } zbuf_ctrl_t;

  // Buffer status
  typedef struct packed {
    logic y_ready;
    logic loaded;
    logic y_pushed;
    logic z_valid;
    logic empty;
  } zbuf_flags_t;

  // One row across all lanes, lane 0 in the low bits
  typedef logic [`ZB_WIDTH-1:0][`ZB_ELEM-1:0] row_t;

endpackage

`default_nettype wire

// File: zbuf_props.sv
`default_nettype none

`include "zbuf_params.svh"

module zbuf_props
  import zbuf_pkg::*;
(
  input logic                            clk_i,
  input logic                            rst_ni,
  input logic                            clear_i,
  input zbuf_ctrl_t                      ctrl_i,
  input zbuf_flags_t                     flags_i,
  input logic [`ZB_DEPTH*`ZB_ELEM-1:0]   z_data_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0;

  // A draining tile keeps z_valid up and y_ready down until its last column leaves
  a_drain_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flags_i.z_valid && !flags_i.empty && !clear_i |=> flags_i.z_valid && !flags_i.y_ready)
    else begin
      $error("y_ready rose or z_valid dropped before the tile drained");
      fail_count++;
    end

  // z_valid is high exactly in PUSHED, where no fill may land
  a_no_fill_pushed: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(ctrl_i.fill && flags_i.z_valid))
    else begin
      $error("fill strobe seen in PUSHED");
      fail_count++;
    end

  a_data_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flags_i.z_valid && !ctrl_i.ready && !clear_i |=> $stable(z_data_i))
    else begin
      $error("z_data changed under back-pressure");
      fail_count++;
    end

endmodule

`default_nettype wire

// File: zbuf_scm.sv
`default_nettype none

`include "zbuf_params.svh"

module zbuf_scm
  import zbuf_pkg::*;
#(
  localparam int unsigned W   = `ZB_WIDTH,
  localparam int unsigned D   = `ZB_DEPTH,
  localparam int unsigned E   = `ZB_ELEM,
  localparam int unsigned DW  = D * E,
  localparam int unsigned DIW = $clog2(D),
  localparam int unsigned WIW = $clog2(W)
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           clear_i,
  input  logic           row_we_i,
  input  logic           col_we_i,
  input  logic [DIW-1:0] row_waddr_i,
  input  logic [WIW-1:0] col_waddr_i,
  input  row_t           row_wdata_i,
  input  logic [DW-1:0]  col_wdata_i,
  input  logic           row_re_i,
  input  logic           col_re_i,
  input  logic [DIW-1:0] row_raddr_i,
  input  logic [WIW-1:0] col_raddr_i,
  output row_t           row_rdata_o,
  output logic [DW-1:0]  col_rdata_o
);

  // Element array, indexed as mem_q[row][lane]
  row_t mem_q [D];

  always_ff @(posedge clk_i) begin
    if (row_we_i) begin
      mem_q[row_waddr_i] <= row_wdata_i;
    end
    if (col_we_i) begin
      for (int r = 0; r < D; r++) begin
        mem_q[r][col_waddr_i] <= col_wdata_i[r*E +: E];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      row_rdata_o <= '0;
      col_rdata_o <= '0;
    end else if (clear_i) begin
      row_rdata_o <= '0;
      col_rdata_o <= '0;
    end else begin
      if (row_re_i) begin
        row_rdata_o <= mem_q[row_raddr_i];
      end
      if (col_re_i) begin
        for (int r = 0; r < D; r++) begin
          // Write-first, a row landing this cycle is seen by the column read
          if (row_we_i && row_waddr_i == DIW'(r)) begin
            col_rdata_o[r*E +: E] <= row_wdata_i[col_raddr_i];
          end else begin
            col_rdata_o[r*E +: E] <= mem_q[r][col_raddr_i];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: zbuf_seq.sv
`default_nettype none

module zbuf_seq (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,
  input  logic       loaded_i,
  input  logic       y_pushed_i,
  input  logic [2:0] rows_i,
  output logic       push_o
);

  logic       loaded_q;
  logic [2:0] cnt_q;
  logic       start, stop;

  // A burst opens on the rising edge of loaded
  assign start = loaded_i && !loaded_q;

  // Stop on the buffer's last-row flag, the count caps the burst at rows
  assign stop = push_o && (y_pushed_i || cnt_q == rows_i - 3'd1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      loaded_q <= 1'b0;
      push_o   <= 1'b0;
      cnt_q    <= '0;
    end else if (clear_i) begin
      loaded_q <= 1'b0;
      push_o   <= 1'b0;
      cnt_q    <= '0;
    end else begin
      loaded_q <= loaded_i;
      if (start) begin
        push_o <= 1'b1;
        cnt_q  <= '0;
      end else if (stop) begin
        push_o <= 1'b0;
      end else if (push_o) begin
        cnt_q <= cnt_q + 3'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: zbuf_top.sv
`default_nettype none

`include "zbuf_params.svh"

module zbuf_top
  import zbuf_pkg::*;
#(
  localparam int unsigned DW = `ZB_DEPTH * `ZB_ELEM
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            clear_i,
  input  zbuf_cfg_t       cfg_i,
  input  row_t            x_i,
  input  logic            y_valid_i,
  input  logic [DW-1:0]   y_data_i,
  input  logic            z_ready_i,
  output logic            y_ready_o,
  output logic            z_valid_o,
  output logic [DW-1:0]   z_data_o,
  output logic [DW/8-1:0] z_strb_o,
  output logic            tile_done_o
);

  zbuf_ctrl_t  ctrl;
  zbuf_flags_t flags;
  row_t        row_to_pe, row_from_pe;
  logic        push, fill;

  assign ctrl.y_valid       = y_valid_i;
  assign ctrl.fill          = fill;
  assign ctrl.y_push_enable = push;
  assign ctrl.ready         = z_ready_i;
  assign ctrl.cfg           = cfg_i;

  zbuf_seq i_seq (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear_i    (clear_i),
    .loaded_i   (flags.loaded),
    .y_pushed_i (flags.y_pushed),
    .rows_i     (cfg_i.rows),
    .push_o     (push)
  );

  zbuf i_zbuf (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (clear_i),
    .ctrl_i   (ctrl),
    .row_i    (row_from_pe),
    .y_data_i (y_data_i),
    .row_o    (row_to_pe),
    .z_data_o (z_data_o),
    .z_strb_o (z_strb_o),
    .flags_o  (flags)
  );

  // Stand-in for the compute array
  lane_adder i_lane_adder (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (clear_i),
    .push_i  (push),
    .row_i   (row_to_pe),
    .x_i     (x_i),
    .fill_o  (fill),
    .row_o   (row_from_pe)
  );

  assign y_ready_o   = flags.y_ready;
  assign z_valid_o   = flags.z_valid;
  assign tile_done_o = flags.empty;

endmodule

`default_nettype wire
